//--- all.f
rtl/axil_pkg.sv
rtl/axil_arbiter_2x1.sv
rtl/axil_sram_slave.sv
rtl/axil_mem_subsys.sv
verification/tb_clk_gen.sv
verification/tb_axil_mem_subsys.sv

//--- rtl/axil_arbiter_2x1.sv
// AXI-lite 2x1 arbiter
`timescale 1ns/1ps

module axil_arbiter_2x1 (
  input  logic               i_aclk,
  input  logic               i_rst_n,

  // ----------------------------
  // Master A
  input  logic               i_a_aw_valid,
  input  axil_pkg::axil_aw_t i_a_aw,
  output logic               o_a_aw_ready,
  input  logic               i_a_w_valid,
  input  axil_pkg::axil_w_t  i_a_w,
  output logic               o_a_w_ready,
  output logic               o_a_b_valid,
  output axil_pkg::axil_b_t  o_a_b,
  input  logic               i_a_b_ready,
  input  logic               i_a_ar_valid,
  input  axil_pkg::axil_ar_t i_a_ar,
  output logic               o_a_ar_ready,
  output logic               o_a_r_valid,
  output axil_pkg::axil_r_t  o_a_r,
  input  logic               i_a_r_ready,

  // ----------------------------
  // Master B
  input  logic               i_b_aw_valid,
  input  axil_pkg::axil_aw_t i_b_aw,
  output logic               o_b_aw_ready,
  input  logic               i_b_w_valid,
  input  axil_pkg::axil_w_t  i_b_w,
  output logic               o_b_w_ready,
  output logic               o_b_b_valid,
  output axil_pkg::axil_b_t  o_b_b,
  input  logic               i_b_b_ready,
  input  logic               i_b_ar_valid,
  input  axil_pkg::axil_ar_t i_b_ar,
  output logic               o_b_ar_ready,
  output logic               o_b_r_valid,
  output axil_pkg::axil_r_t  o_b_r,
  input  logic               i_b_r_ready,

  // ----------------------------
  // Downstream slave
  output logic               o_aw_valid,
  output axil_pkg::axil_aw_t o_aw,
  input  logic               i_aw_ready,
  output logic               o_w_valid,
  output axil_pkg::axil_w_t  o_w,
  input  logic               i_w_ready,
  input  logic               i_b_valid,
  input  axil_pkg::axil_b_t  i_b,
  output logic               o_b_ready,
  output logic               o_ar_valid,
  output axil_pkg::axil_ar_t o_ar,
  input  logic               i_ar_ready,
  input  logic               i_r_valid,
  input  axil_pkg::axil_r_t  i_r,
  output logic               o_r_ready
);
  import axil_pkg::*;

  arb_state_e wr_state;
  arb_state_e rd_state;
  logic       wr_a;
  logic       wr_b;
  logic       rd_a;
  logic       rd_b;

  // Fixed priority to A, grant kept until the response handshake
  function automatic arb_state_e next_grant(
    input arb_state_e cur,
    input logic       a_req,
    input logic       b_req,
    input logic       rsp_done
  );
    arb_state_e nxt;
    nxt = cur;
    case (cur)
      ARB_IDLE: begin
        if (a_req) begin
          nxt = ARB_A;
        end else if (b_req) begin
          nxt = ARB_B;
        end
      end
      default: begin
        if (rsp_done) begin
          nxt = ARB_IDLE;
        end
      end
    endcase
    return nxt;
  endfunction

  always_ff @(posedge i_aclk) begin
    if (!i_rst_n) begin
      wr_state <= ARB_IDLE;
      rd_state <= ARB_IDLE;
    end else begin
      wr_state <= next_grant(wr_state, i_a_aw_valid, i_b_aw_valid, i_b_valid & o_b_ready);
      rd_state <= next_grant(rd_state, i_a_ar_valid, i_b_ar_valid, i_r_valid & o_r_ready);
    end
  end

  assign wr_a = (wr_state == ARB_A);
  assign wr_b = (wr_state == ARB_B);
  assign rd_a = (rd_state == ARB_A);
  assign rd_b = (rd_state == ARB_B);

  // Write direction
  assign o_aw_valid   = (wr_a & i_a_aw_valid) | (wr_b & i_b_aw_valid);
  assign o_aw         = wr_b ? i_b_aw : i_a_aw;
  assign o_a_aw_ready = wr_a & i_aw_ready;
  assign o_b_aw_ready = wr_b & i_aw_ready;
  assign o_w_valid    = (wr_a & i_a_w_valid) | (wr_b & i_b_w_valid);
  assign o_w          = wr_b ? i_b_w : i_a_w;
  assign o_a_w_ready  = wr_a & i_w_ready;
  assign o_b_w_ready  = wr_b & i_w_ready;
  assign o_a_b_valid  = wr_a & i_b_valid;
  assign o_b_b_valid  = wr_b & i_b_valid;
  assign o_a_b        = wr_a ? i_b : '0;  // Zeroed toward the idle side
  assign o_b_b        = wr_b ? i_b : '0;
  assign o_b_ready    = (wr_a & i_a_b_ready) | (wr_b & i_b_b_ready);

  // Read direction
  assign o_ar_valid   = (rd_a & i_a_ar_valid) | (rd_b & i_b_ar_valid);
  assign o_ar         = rd_b ? i_b_ar : i_a_ar;
  assign o_a_ar_ready = rd_a & i_ar_ready;
  assign o_b_ar_ready = rd_b & i_ar_ready;
  assign o_a_r_valid  = rd_a & i_r_valid;
  assign o_b_r_valid  = rd_b & i_r_valid;
  assign o_a_r        = rd_a ? i_r : '0;
  assign o_b_r        = rd_b ? i_r : '0;
  assign o_r_ready    = (rd_a & i_a_r_ready) | (rd_b & i_b_r_ready);

  // Slave only answers a request issued under a grant
  assert property (@(posedge i_aclk) disable iff (!i_rst_n)
    !(i_b_valid && wr_state == ARB_IDLE) && !(i_r_valid && rd_state == ARB_IDLE))
    else $error("response with no grant held");

  // A waiting response pins its grant
  assert property (@(posedge i_aclk) disable iff (!i_rst_n)
    (!$past(i_b_valid && !o_b_ready) || wr_state == $past(wr_state)) &&
    (!$past(i_r_valid && !o_r_ready) || rd_state == $past(rd_state)))
    else $error("grant moved while a response was pending");

endmodule

//--- rtl/axil_mem_subsys.sv
// Two-master SRAM subsystem
`timescale 1ns/1ps

module axil_mem_subsys (
  input  logic               i_aclk,
  input  logic               i_rst_n,

  // ----------------------------
  // Master A
  input  logic               i_a_aw_valid,
  input  axil_pkg::axil_aw_t i_a_aw,
  output logic               o_a_aw_ready,
  input  logic               i_a_w_valid,
  input  axil_pkg::axil_w_t  i_a_w,
  output logic               o_a_w_ready,
  output logic               o_a_b_valid,
  output axil_pkg::axil_b_t  o_a_b,
  input  logic               i_a_b_ready,
  input  logic               i_a_ar_valid,
  input  axil_pkg::axil_ar_t i_a_ar,
  output logic               o_a_ar_ready,
  output logic               o_a_r_valid,
  output axil_pkg::axil_r_t  o_a_r,
  input  logic               i_a_r_ready,

  // ----------------------------
  // Master B
  input  logic               i_b_aw_valid,
  input  axil_pkg::axil_aw_t i_b_aw,
  output logic               o_b_aw_ready,
  input  logic               i_b_w_valid,
  input  axil_pkg::axil_w_t  i_b_w,
  output logic               o_b_w_ready,
  output logic               o_b_b_valid,
  output axil_pkg::axil_b_t  o_b_b,
  input  logic               i_b_b_ready,
  input  logic               i_b_ar_valid,
  input  axil_pkg::axil_ar_t i_b_ar,
  output logic               o_b_ar_ready,
  output logic               o_b_r_valid,
  output axil_pkg::axil_r_t  o_b_r,
  input  logic               i_b_r_ready
);
  import axil_pkg::*;

  // Arbiter to SRAM
  logic     aw_valid;
  axil_aw_t aw;
  logic     aw_ready;
  logic     w_valid;
  axil_w_t  w;
  logic     w_ready;
  logic     b_valid;
  axil_b_t  b;
  logic     b_ready;
  logic     ar_valid;
  axil_ar_t ar;
  logic     ar_ready;
  logic     r_valid;
  axil_r_t  r;
  logic     r_ready;

  // Master sides share names with the top ports
  axil_arbiter_2x1 u_arbiter (
    .*,
    .o_aw_valid (aw_valid),
    .o_aw       (aw),
    .i_aw_ready (aw_ready),
    .o_w_valid  (w_valid),
    .o_w        (w),
    .i_w_ready  (w_ready),
    .i_b_valid  (b_valid),
    .i_b        (b),
    .o_b_ready  (b_ready),
    .o_ar_valid (ar_valid),
    .o_ar       (ar),
    .i_ar_ready (ar_ready),
    .i_r_valid  (r_valid),
    .i_r        (r),
    .o_r_ready  (r_ready)
  );

  axil_sram_slave u_sram (
    .i_aclk     (i_aclk),
    .i_rst_n    (i_rst_n),
    .i_aw_valid (aw_valid),
    .i_aw       (aw),
    .o_aw_ready (aw_ready),
    .i_w_valid  (w_valid),
    .i_w        (w),
    .o_w_ready  (w_ready),
    .o_b_valid  (b_valid),
    .o_b        (b),
    .i_b_ready  (b_ready),
    .i_ar_valid (ar_valid),
    .i_ar       (ar),
    .o_ar_ready (ar_ready),
    .o_r_valid  (r_valid),
    .o_r        (r),
    .i_r_ready  (r_ready)
  );

endmodule

//--- rtl/axil_pkg.sv
// AXI-lite bus definitions
package axil_pkg;

  // ----------------------------
  // Bus widths and SRAM size
  localparam int AXIL_ADDR_W    = 32;
  localparam int AXIL_DATA_W    = 64;
  localparam int AXIL_STRB_W    = AXIL_DATA_W / 8;  // One bit per byte
  localparam int MEM_WORDS_LOG2 = 8;                // 256 words of 8 bytes

  typedef logic [AXIL_ADDR_W-1:0] addr_t;
  typedef logic [AXIL_DATA_W-1:0] data_t;
  typedef logic [AXIL_STRB_W-1:0] strb_t;
  typedef logic [2:0]             prot_t;
  typedef logic [1:0]             resp_t;

  localparam resp_t RESP_OKAY   = 2'b00;
  localparam resp_t RESP_SLVERR = 2'b10;

  // ----------------------------
  // Channel payloads
  typedef struct packed {
    addr_t addr;
    prot_t prot;
  } axil_aw_t;

  typedef struct packed {
    data_t data;
    strb_t strb;
  } axil_w_t;

  typedef struct packed {
    resp_t resp;
  } axil_b_t;

  typedef struct packed {
    addr_t addr;
    prot_t prot;
  } axil_ar_t;

  typedef struct packed {
    data_t data;
    resp_t resp;
  } axil_r_t;

  // Grant held per direction
  typedef enum logic [1:0] {ARB_IDLE, ARB_A, ARB_B} arb_state_e;

endpackage

//--- rtl/axil_sram_slave.sv
// AXI-lite SRAM slave
`timescale 1ns/1ps

module axil_sram_slave (
  input  logic               i_aclk,
  input  logic               i_rst_n,

  input  logic               i_aw_valid,
  input  axil_pkg::axil_aw_t i_aw,
  output logic               o_aw_ready,

  input  logic               i_w_valid,
  input  axil_pkg::axil_w_t  i_w,
  output logic               o_w_ready,

  output logic               o_b_valid,
  output axil_pkg::axil_b_t  o_b,
  input  logic               i_b_ready,

  input  logic               i_ar_valid,
  input  axil_pkg::axil_ar_t i_ar,
  output logic               o_ar_ready,

  output logic               o_r_valid,
  output axil_pkg::axil_r_t  o_r,
  input  logic               i_r_ready
);
  import axil_pkg::*;

  data_t mem [2**MEM_WORDS_LOG2];

  logic [MEM_WORDS_LOG2-1:0] wr_idx;
  logic [MEM_WORDS_LOG2-1:0] rd_idx;
  logic                      wr_oor;
  logic                      rd_oor;
  logic                      wr_fire;
  logic                      rd_fire;

  // ----------------------------
  // Address decode
  // Byte offset bits dropped, anything above the index is out of range
  assign wr_idx = i_aw.addr[$clog2(AXIL_STRB_W) +: MEM_WORDS_LOG2];
  assign rd_idx = i_ar.addr[$clog2(AXIL_STRB_W) +: MEM_WORDS_LOG2];
  assign wr_oor = |(i_aw.addr >> ($clog2(AXIL_STRB_W) + MEM_WORDS_LOG2));
  assign rd_oor = |(i_ar.addr >> ($clog2(AXIL_STRB_W) + MEM_WORDS_LOG2));

  // ----------------------------
  // Handshakes
  assign wr_fire    = i_aw_valid & i_w_valid & ~o_b_valid;  // AW and W taken together
  assign o_aw_ready = wr_fire;
  assign o_w_ready  = wr_fire;
  assign rd_fire    = i_ar_valid & ~o_r_valid;
  assign o_ar_ready = rd_fire;

  // Strobed byte merge
  always_ff @(posedge i_aclk) begin
    if (wr_fire && !wr_oor) begin
      for (int i = 0; i < AXIL_STRB_W; i++) begin
        if (i_w.strb[i]) begin
          mem[wr_idx][8*i +: 8] <= i_w.data[8*i +: 8];
        end
      end
    end
  end

  // Response valids held until accepted
  always_ff @(posedge i_aclk) begin
    if (!i_rst_n) begin
      o_b_valid <= 1'b0;
      o_r_valid <= 1'b0;
    end else begin
      o_b_valid <= wr_fire | (o_b_valid & ~i_b_ready);
      o_r_valid <= rd_fire | (o_r_valid & ~i_r_ready);
    end
  end

  // Payloads load only when the channel is free
  always_ff @(posedge i_aclk) begin
    if (wr_fire) begin
      o_b.resp <= wr_oor ? RESP_SLVERR : RESP_OKAY;
    end
    if (rd_fire) begin
      o_r.data <= rd_oor ? '0 : mem[rd_idx];  // Out of range reads as zero
      o_r.resp <= rd_oor ? RESP_SLVERR : RESP_OKAY;
    end
  end

  // Stalled response stays put until the master takes it
  assert property (@(posedge i_aclk) disable iff (!i_rst_n)
    (!$past(o_b_valid && !i_b_ready) || (o_b_valid && o_b == $past(o_b))) &&
    (!$past(o_r_valid && !i_r_ready) || (o_r_valid && o_r == $past(o_r))))
    else $error("response changed before it was accepted");

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --top-module tb_axil_mem_subsys \
  --Mdir obj_dir -o sim_tb \
  -f all.f

out=$(./obj_dir/sim_tb 2>&1) || true
echo "$out"

if grep -q "ALL TESTS PASSED" <<< "$out"; then
  exit 0
else
  exit 1
fi

//--- verification/tb_axil_mem_subsys.sv
// Memory subsystem testbench
`timescale 1ns/1ps

module tb_axil_mem_subsys;
  import axil_pkg::*;

  localparam int TIMEOUT    = 100;
  localparam int IDLE_EDGES = 2;  // Grant edge plus slave response edge

  logic           clk;
  logic           rst_n;
  logic     [1:0] aw_valid;
  logic     [1:0] aw_ready;
  logic     [1:0] w_valid;
  logic     [1:0] w_ready;
  logic     [1:0] b_valid;
  logic     [1:0] b_ready;
  logic     [1:0] ar_valid;
  logic     [1:0] ar_ready;
  logic     [1:0] r_valid;
  logic     [1:0] r_ready;
  axil_aw_t [1:0] aw;
  axil_w_t  [1:0] w;
  axil_b_t  [1:0] b;
  axil_ar_t [1:0] ar;
  axil_r_t  [1:0] r;

  data_t  shadow [2**MEM_WORDS_LOG2];  // Expected SRAM contents
  integer seed = 32'h8b16_b1c4;
  int     err_data;
  int     err_resp;
  int     err_lat;
  int     err_fault;
  int     done_seq;
  int     done_at [2];  // Completion order per master

  tb_clk_gen u_clk_gen (.o_clk(clk), .o_rst_n(rst_n));

  axil_mem_subsys UUT (
    .i_aclk       (clk),          .i_rst_n      (rst_n),
    .i_a_aw_valid (aw_valid[0]),  .i_a_aw       (aw[0]),     .o_a_aw_ready (aw_ready[0]),
    .i_a_w_valid  (w_valid[0]),   .i_a_w        (w[0]),      .o_a_w_ready  (w_ready[0]),
    .o_a_b_valid  (b_valid[0]),   .o_a_b        (b[0]),      .i_a_b_ready  (b_ready[0]),
    .i_a_ar_valid (ar_valid[0]),  .i_a_ar       (ar[0]),     .o_a_ar_ready (ar_ready[0]),
    .o_a_r_valid  (r_valid[0]),   .o_a_r        (r[0]),      .i_a_r_ready  (r_ready[0]),
    .i_b_aw_valid (aw_valid[1]),  .i_b_aw       (aw[1]),     .o_b_aw_ready (aw_ready[1]),
    .i_b_w_valid  (w_valid[1]),   .i_b_w        (w[1]),      .o_b_w_ready  (w_ready[1]),
    .o_b_b_valid  (b_valid[1]),   .o_b_b        (b[1]),      .i_b_b_ready  (b_ready[1]),
    .i_b_ar_valid (ar_valid[1]),  .i_b_ar       (ar[1]),     .o_b_ar_ready (ar_ready[1]),
    .o_b_r_valid  (r_valid[1]),   .o_b_r        (r[1]),      .i_b_r_ready  (r_ready[1])
  );

  // ----------------------------
  // Compare and report helpers
  task automatic check_data(input data_t got, input data_t exp, input string msg);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t: %s, got %h, expected %h", $time, msg, got, exp);
      err_data++;
    end
  endtask

  task automatic check_resp(input resp_t got, input resp_t exp, input string msg);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t: %s, got %b, expected %b", $time, msg, got, exp);
      err_resp++;
    end
  endtask

  task automatic check_edges(input int got, input int exp, input string msg);
    if (got != exp) begin
      $display("CHECK FAILED at %0t: %s, got %0d edges, expected %0d", $time, msg, got, exp);
      err_lat++;
    end
  endtask

  task automatic report_fault(input string msg);
    $display("ERROR at %0t: %s", $time, msg);
    err_fault++;
  endtask

  function automatic data_t rand_word();
    return {$random(seed), $random(seed)};
  endfunction

  // Byte lanes with a strobe bit take the new data
  function automatic data_t merge_bytes(input data_t old_w, input data_t new_w, input strb_t strb);
    data_t res;
    res = old_w;
    for (int i = 0; i < AXIL_STRB_W; i++) begin
      if (strb[i]) res[8*i +: 8] = new_w[8*i +: 8];
    end
    return res;
  endfunction

  // ----------------------------
  // Bus transactions
  task automatic axil_write(input bit m, input addr_t addr, input data_t data, input strb_t strb,
                            output resp_t resp, input int dly, input bit chk_lat);
    int n;
    int edges;
    int i;
    n = 0;
    edges = 0;
    resp = '1;
    @(posedge clk);
    aw_valid[m]  <= 1'b1;
    aw[m].addr   <= addr;
    aw[m].prot   <= '0;
    w_valid[m]   <= 1'b1;
    w[m].data    <= data;
    w[m].strb    <= strb;
    @(negedge clk);
    while (!(aw_ready[m] && w_ready[m])) begin
      n++;
      if (n > TIMEOUT) begin
        report_fault($sformatf("master %0d write to %h was never accepted", m, addr));
        return;
      end
      @(posedge clk);
      edges++;
      @(negedge clk);
    end
    @(posedge clk);  // AW and W transfer
    edges++;
    aw_valid[m] <= 1'b0;
    w_valid[m]  <= 1'b0;
    n = 0;
    @(negedge clk);
    while (!b_valid[m]) begin
      n++;
      if (n > TIMEOUT) begin
        report_fault($sformatf("master %0d got no write response for %h", m, addr));
        return;
      end
      @(posedge clk);
      edges++;
      @(negedge clk);
    end
    if (chk_lat) check_edges(edges, IDLE_EDGES, $sformatf("master %0d B latency", m));
    resp = b[m].resp;
    // Ready held low while the other master stays locked out
    for (i = 0; i <= dly; i++) begin
      if (!b_valid[m] || b_valid[!m] || aw_ready[!m] || w_ready[!m]) begin
        report_fault($sformatf("master %0d write response not held or grant leaked", m));
      end
      check_resp(b[m].resp, resp, "B payload while stalled");
      @(posedge clk);
      if (i == dly) b_ready[m] <= 1'b1;
      @(negedge clk);
    end
    if (!b_valid[m]) report_fault($sformatf("master %0d B valid dropped before ready", m));
    @(posedge clk);  // B transfer
    b_ready[m] <= 1'b0;
    done_seq++;
    done_at[m] = done_seq;
  endtask

  task automatic axil_read(input bit m, input addr_t addr, output data_t data,
                           output resp_t resp, input int dly, input bit chk_lat);
    int n;
    int edges;
    int i;
    n = 0;
    edges = 0;
    data = '0;
    resp = '1;
    @(posedge clk);
    ar_valid[m] <= 1'b1;
    ar[m].addr  <= addr;
    ar[m].prot  <= '0;
    @(negedge clk);
    while (!ar_ready[m]) begin
      n++;
      if (n > TIMEOUT) begin
        report_fault($sformatf("master %0d read of %h was never accepted", m, addr));
        return;
      end
      @(posedge clk);
      edges++;
      @(negedge clk);
    end
    @(posedge clk);  // AR transfer
    edges++;
    ar_valid[m] <= 1'b0;
    n = 0;
    @(negedge clk);
    while (!r_valid[m]) begin
      n++;
      if (n > TIMEOUT) begin
        report_fault($sformatf("master %0d got no read response for %h", m, addr));
        return;
      end
      @(posedge clk);
      edges++;
      @(negedge clk);
    end
    if (chk_lat) check_edges(edges, IDLE_EDGES, $sformatf("master %0d R latency", m));
    data = r[m].data;
    resp = r[m].resp;
    for (i = 0; i <= dly; i++) begin
      if (!r_valid[m] || r_valid[!m] || ar_ready[!m]) begin
        report_fault($sformatf("master %0d read response not held or grant leaked", m));
      end
      check_data(r[m].data, data, "R data while stalled");
      check_resp(r[m].resp, resp, "R resp while stalled");
      @(posedge clk);
      if (i == dly) r_ready[m] <= 1'b1;
      @(negedge clk);
    end
    if (!r_valid[m]) report_fault($sformatf("master %0d R valid dropped before ready", m));
    @(posedge clk);  // R transfer
    r_ready[m] <= 1'b0;
    done_seq++;
    done_at[m] = done_seq;
  endtask

  task automatic write_expect(input bit m, input addr_t addr, input data_t data,
                              input strb_t strb, input int dly, input bit chk_lat);
    resp_t resp;
    axil_write(m, addr, data, strb, resp, dly, chk_lat);
    check_resp(resp, RESP_OKAY, $sformatf("master %0d write %h", m, addr));
    shadow[addr[3 +: MEM_WORDS_LOG2]] = merge_bytes(shadow[addr[3 +: MEM_WORDS_LOG2]], data, strb);
  endtask

  task automatic read_expect(input bit m, input addr_t addr, input int dly, input bit chk_lat);
    data_t data;
    resp_t resp;
    axil_read(m, addr, data, resp, dly, chk_lat);
    check_resp(resp, RESP_OKAY, $sformatf("master %0d read %h", m, addr));
    check_data(data, shadow[addr[3 +: MEM_WORDS_LOG2]], $sformatf("master %0d read %h", m, addr));
  endtask

  // ----------------------------
  // Directed tests
  task automatic test_reset();
    int n;
    n = 0;
    @(posedge clk);
    @(negedge clk);
    // All requests are high here and none may be accepted
    if ({aw_ready, w_ready, ar_ready, b_valid, r_valid} !== '0) begin
      report_fault("valid or ready high during reset");
    end
    @(posedge clk);
    aw_valid <= '0;
    w_valid  <= '0;
    ar_valid <= '0;
    @(negedge clk);
    while (!rst_n) begin
      if ({aw_ready, w_ready, ar_ready, b_valid, r_valid} !== '0) begin
        report_fault("valid or ready high during reset");
      end
      n++;
      if (n > TIMEOUT) begin
        report_fault("reset never released");
        return;
      end
      @(negedge clk);
    end
    if ({aw_ready, w_ready, ar_ready, b_valid, r_valid} !== '0) begin
      report_fault("valid or ready high in the first cycle after reset");
    end
  endtask

  task automatic test_master_a();
    write_expect(0, 32'h0000_0010, rand_word(), 8'hFF, 0, 1);
    write_expect(0, 32'h0000_0010, rand_word(), 8'h3C, 0, 1);  // Middle bytes only
    write_expect(0, 32'h0000_07F8, rand_word(), 8'hFF, 0, 1);  // Last word
    write_expect(0, 32'h0000_07F8, rand_word(), 8'h81, 0, 1);
    read_expect(0, 32'h0000_0010, 0, 1);
    read_expect(0, 32'h0000_07F8, 0, 1);
  endtask

  task automatic test_master_b();
    write_expect(1, 32'h0000_0100, rand_word(), 8'hFF, 0, 1);
    write_expect(1, 32'h0000_0108, rand_word(), 8'hFF, 0, 1);
    write_expect(1, 32'h0000_0100, rand_word(), 8'hF0, 0, 1);
    read_expect(0, 32'h0000_0100, 0, 1);  // Read back through the other port
    read_expect(0, 32'h0000_0108, 0, 1);
  endtask

  task automatic test_contention();
    data_t d0;
    data_t d1;
    d0 = rand_word();
    d1 = rand_word();
    fork
      write_expect(0, 32'h0000_0200, d0, 8'hFF, 0, 1);
      write_expect(1, 32'h0000_0208, d1, 8'hFF, 0, 0);
    join
    if (done_at[0] > done_at[1]) report_fault("master B write finished before master A");
    fork
      read_expect(0, 32'h0000_0200, 0, 1);
      read_expect(1, 32'h0000_0208, 0, 0);
    join
    if (done_at[0] > done_at[1]) report_fault("master B read finished before master A");
  endtask

  task automatic test_out_of_range();
    data_t data;
    resp_t resp;
    write_expect(0, 32'h0000_0040, rand_word(), 8'hFF, 0, 1);
    axil_write(0, 32'h0000_0840, rand_word(), 8'hFF, resp, 0, 1);  // Aliases word 8
    check_resp(resp, RESP_SLVERR, "out-of-range write");
    axil_read(0, 32'h0000_0840, data, resp, 0, 1);
    check_resp(resp, RESP_SLVERR, "out-of-range read");
    check_data(data, '0, "out-of-range read data");
    read_expect(1, 32'h0000_0040, 0, 1);
  endtask

  task automatic test_backpressure();
    int dly0;
    int dly1;
    repeat (4) begin
      dly0 = $unsigned($random(seed)) % 8;
      dly1 = $unsigned($random(seed)) % 8;
      fork
        write_expect(0, 32'h0000_0010, rand_word(), strb_t'($random(seed)), dly0, 0);
        write_expect(1, 32'h0000_0100, rand_word(), strb_t'($random(seed)), dly1, 0);
      join
      fork
        read_expect(0, 32'h0000_0100, dly1, 0);  // Each reads what the other wrote
        read_expect(1, 32'h0000_0010, dly0, 0);
      join
    end
  endtask

  initial begin
    aw_valid <= '1;  // Requests raised into reset
    w_valid  <= '1;
    b_ready  <= '0;
    ar_valid <= '1;
    r_ready  <= '0;
    aw       <= '0;
    w        <= '0;
    ar       <= '0;
    test_reset();
    test_master_a();
    test_master_b();
    test_contention();
    test_out_of_range();
    test_backpressure();
    $display("Errors: data %0d, resp %0d, latency %0d, other %0d",
             err_data, err_resp, err_lat, err_fault);
    if (err_data + err_resp + err_lat + err_fault == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

//--- verification/tb_clk_gen.sv
// Testbench clock and reset
`timescale 1ns/1ps

module tb_clk_gen (
  output logic o_clk,
  output logic o_rst_n
);

  initial begin
    o_clk = 1'b0;
    forever #10 o_clk = ~o_clk;  // 20 ns period
  end

  initial begin
    o_rst_n = 1'b0;
    repeat (2) @(posedge o_clk);
    o_rst_n <= 1'b1;
  end

endmodule
